// ==== all.f ====
source/cpu_pkg.sv
source/opcode_decoder.sv
source/address_phase.sv
source/execute_phase.sv
source/control_sequencer.sv
source/control_unit.sv
test/tb_clock.sv
test/control_unit_props.sv
test/control_unit_tb.sv

// ==== source/address_phase.sv ====
`timescale 1ns/1ps

module address_phase (
  input  cpu_pkg::instr_state_t   state,
  input  cpu_pkg::addr_mode_t     mode,
  input  logic                    carry_flag,
  output cpu_pkg::ctrl_word_t     ctrl,
  output cpu_pkg::data_bus_src_t  data_bus_src,
  output cpu_pkg::addr_low_src_t  addr_low_src,
  output cpu_pkg::addr_high_src_t addr_high_src,
  output cpu_pkg::instr_state_t   next_state
);
  import cpu_pkg::*;

  logic indexed;

  assign indexed = (mode == mode_abs_x) || (mode == mode_abs_y);

  // Operand address during the execute cycles.
  always_comb begin
    addr_low_src = addr_low_src_pc;
    addr_high_src = addr_high_src_pc;
    if (state inside {st_exec1, st_exec2, st_exec3}) begin
      if (mode == mode_zpg) begin
        addr_low_src = addr_low_src_reg;
        addr_high_src = addr_high_src_zero;
      end else if (mode == mode_abs || indexed) begin
        addr_low_src = addr_low_src_reg;
        addr_high_src = addr_high_src_reg;
      end
    end
  end

  always_comb begin
    ctrl = '0;
    data_bus_src = data_src_data_in;
    case (state)
      st_decode: begin
        if (indexed) begin
          data_bus_src = (mode == mode_abs_x) ? data_src_x : data_src_y; // Index to ALU A.
          ctrl[ctrl_load_input_a] = 1'b1;
          ctrl[ctrl_clear_carry] = 1'b1;
          next_state = st_mem1;
        end else if (mode == mode_abs || mode == mode_zpg) begin
          ctrl[ctrl_inc_pc] = 1'b1;
          ctrl[ctrl_load_addr_low] = 1'b1;
          next_state = (mode == mode_abs) ? st_mem1 : st_exec1;
        end else begin
          next_state = st_exec1; // Immediate and implied.
        end
      end
      st_mem1: begin
        ctrl[ctrl_inc_pc] = 1'b1;
        if (indexed) begin
          ctrl[ctrl_load_input_b] = 1'b1; // Low address byte.
          next_state = st_mem2;
        end else begin
          ctrl[ctrl_load_addr_high] = 1'b1;
          next_state = st_exec1;
        end
      end
      st_mem2: begin
        data_bus_src = data_src_alu;
        ctrl[ctrl_update_c] = 1'b1; // Carry marks a page cross.
        ctrl[ctrl_load_addr_low] = 1'b1;
        next_state = st_mem3;
      end
      st_mem3: begin
        ctrl[ctrl_inc_pc] = 1'b1;
        ctrl[ctrl_load_addr_high] = 1'b1;
        next_state = carry_flag ? st_mem4 : st_exec1;
      end
      st_mem4: begin
        ctrl[ctrl_inc_addr_high] = 1'b1;
        next_state = st_exec1;
      end
      default: next_state = st_invalid;
    endcase
  end

endmodule

// ==== source/control_sequencer.sv ====
`timescale 1ns/1ps

module control_sequencer (
  input  logic                    clk,
  input  logic                    reset,
  input  cpu_pkg::addr_mode_t     decoded_mode,
  input  cpu_pkg::op_class_t      decoded_class,
  input  logic                    valid,
  input  cpu_pkg::ctrl_word_t     addr_ctrl,
  input  cpu_pkg::data_bus_src_t  addr_data_src,
  input  cpu_pkg::addr_low_src_t  addr_low_in,
  input  cpu_pkg::addr_high_src_t addr_high_in,
  input  cpu_pkg::instr_state_t   addr_next,
  input  cpu_pkg::ctrl_word_t     exec_ctrl,
  input  cpu_pkg::data_bus_src_t  exec_data_src,
  input  cpu_pkg::alu_op_t        exec_alu_op,
  input  cpu_pkg::instr_state_t   exec_next,
  output cpu_pkg::instr_state_t   state,
  output cpu_pkg::addr_mode_t     mode,
  output cpu_pkg::ctrl_word_t     ctrl,
  output cpu_pkg::alu_op_t        alu_op,
  output cpu_pkg::data_bus_src_t  data_bus_src,
  output cpu_pkg::addr_low_src_t  addr_low_src,
  output cpu_pkg::addr_high_src_t addr_high_src,
  output logic                    halted
);
  import cpu_pkg::*;

  instr_state_t next_state;
  addr_mode_t mode_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      mode_q <= mode_impl;
    end else begin
      state <= next_state;
      if (state == st_decode) begin
        mode_q <= decoded_mode;
      end
    end
  end

  // Decode sees the mode straight from the decoder.
  assign mode = (state == st_decode) ? decoded_mode : mode_q;
  assign halted = (state == st_invalid);

  always_comb begin
    ctrl = '0;
    alu_op = alu_add;
    data_bus_src = data_src_data_in;
    addr_low_src = addr_low_src_pc;
    addr_high_src = addr_high_src_pc;
    case (state)
      st_fetch: begin
        ctrl[ctrl_load_inst_reg] = 1'b1;
        ctrl[ctrl_inc_pc] = 1'b1;
        next_state = st_decode;
      end
      st_decode, st_mem1, st_mem2, st_mem3, st_mem4: begin
        ctrl = addr_ctrl;
        data_bus_src = addr_data_src;
        addr_low_src = addr_low_in;
        addr_high_src = addr_high_in;
        if (state == st_decode && !valid) begin
          next_state = st_invalid;
        end else if (state == st_decode && decoded_class == op_nop) begin
          next_state = st_fetch;
        end else begin
          next_state = addr_next;
        end
      end
      st_exec1, st_exec2, st_exec3: begin
        ctrl = exec_ctrl;
        alu_op = exec_alu_op;
        data_bus_src = exec_data_src;
        addr_low_src = addr_low_in;
        addr_high_src = addr_high_in;
        next_state = exec_next;
      end
      default: next_state = st_invalid; // Trapped until reset.
    endcase
  end

endmodule

// ==== source/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  cpu_pkg::opcode_t        opcode,
  input  logic                    carry_flag,
  output cpu_pkg::ctrl_word_t     ctrl,
  output cpu_pkg::alu_op_t        alu_op,
  output cpu_pkg::data_bus_src_t  data_bus_src,
  output cpu_pkg::addr_low_src_t  addr_low_src,
  output cpu_pkg::addr_high_src_t addr_high_src,
  output logic                    halted
);
  import cpu_pkg::*;

  addr_mode_t decoded_mode;
  addr_mode_t mode;
  op_class_t op_class;
  reg_t reg_sel;
  reg_t src_sel;
  alu_op_t alu_sel;
  logic valid;
  instr_state_t state;

  ctrl_word_t addr_ctrl;
  data_bus_src_t addr_data_src;
  addr_low_src_t addr_low;
  addr_high_src_t addr_high;
  instr_state_t addr_next;

  ctrl_word_t exec_ctrl;
  data_bus_src_t exec_data_src;
  alu_op_t exec_alu_op;
  instr_state_t exec_next;

  opcode_decoder decoder0 (
    .opcode(opcode), .mode(decoded_mode), .op_class(op_class), .reg_sel(reg_sel),
    .src_sel(src_sel), .alu_sel(alu_sel), .valid(valid)
  );

  address_phase address0 (
    .state(state), .mode(mode), .carry_flag(carry_flag), .ctrl(addr_ctrl),
    .data_bus_src(addr_data_src), .addr_low_src(addr_low), .addr_high_src(addr_high),
    .next_state(addr_next)
  );

  execute_phase execute0 (
    .state(state), .op_class(op_class), .reg_sel(reg_sel), .src_sel(src_sel),
    .alu_sel(alu_sel), .mode(mode), .carry_flag(carry_flag), .ctrl(exec_ctrl),
    .data_bus_src(exec_data_src), .alu_op(exec_alu_op), .next_state(exec_next)
  );

  control_sequencer sequencer0 (
    .clk(clk), .reset(reset), .decoded_mode(decoded_mode), .decoded_class(op_class),
    .valid(valid), .addr_ctrl(addr_ctrl), .addr_data_src(addr_data_src),
    .addr_low_in(addr_low), .addr_high_in(addr_high), .addr_next(addr_next),
    .exec_ctrl(exec_ctrl), .exec_data_src(exec_data_src), .exec_alu_op(exec_alu_op),
    .exec_next(exec_next), .state(state), .mode(mode), .ctrl(ctrl), .alu_op(alu_op),
    .data_bus_src(data_bus_src), .addr_low_src(addr_low_src),
    .addr_high_src(addr_high_src), .halted(halted)
  );

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

  // Kept opcodes, with their 6502 encodings.
  typedef enum logic [7:0] {
    opc_lda_imm = 8'ha9, opc_lda_abs = 8'had, opc_lda_absx = 8'hbd, opc_lda_absy = 8'hb9,
    opc_lda_zpg = 8'ha5,
    opc_ldx_imm = 8'ha2, opc_ldx_abs = 8'hae, opc_ldx_absy = 8'hbe, opc_ldx_zpg = 8'ha6,
    opc_ldy_imm = 8'ha0, opc_ldy_abs = 8'hac, opc_ldy_absx = 8'hbc, opc_ldy_zpg = 8'ha4,
    opc_sta_abs = 8'h8d, opc_sta_absx = 8'h9d, opc_sta_absy = 8'h99, opc_sta_zpg = 8'h85,
    opc_stx_abs = 8'h8e, opc_stx_zpg = 8'h86,
    opc_sty_abs = 8'h8c, opc_sty_zpg = 8'h84,
    opc_adc_imm = 8'h69, opc_adc_abs = 8'h6d, opc_adc_absx = 8'h7d, opc_adc_absy = 8'h79,
    opc_adc_zpg = 8'h65,
    opc_sbc_imm = 8'he9, opc_sbc_abs = 8'hed, opc_sbc_absx = 8'hfd, opc_sbc_absy = 8'hf9,
    opc_sbc_zpg = 8'he5,
    opc_cmp_imm = 8'hc9, opc_cmp_abs = 8'hcd, opc_cmp_absx = 8'hdd, opc_cmp_absy = 8'hd9,
    opc_cmp_zpg = 8'hc5,
    opc_cpx_imm = 8'he0, opc_cpx_abs = 8'hec, opc_cpx_zpg = 8'he4,
    opc_cpy_imm = 8'hc0, opc_cpy_abs = 8'hcc, opc_cpy_zpg = 8'hc4,
    opc_and_imm = 8'h29, opc_and_abs = 8'h2d, opc_and_absx = 8'h3d, opc_and_absy = 8'h39,
    opc_and_zpg = 8'h25,
    opc_ora_imm = 8'h09, opc_ora_abs = 8'h0d, opc_ora_absx = 8'h1d, opc_ora_absy = 8'h19,
    opc_ora_zpg = 8'h05,
    opc_eor_imm = 8'h49, opc_eor_abs = 8'h4d, opc_eor_absx = 8'h5d, opc_eor_absy = 8'h59,
    opc_eor_zpg = 8'h45,
    opc_tax = 8'haa, opc_tay = 8'ha8, opc_txa = 8'h8a, opc_tya = 8'h98,
    opc_inx = 8'he8, opc_iny = 8'hc8, opc_clc = 8'h18, opc_sec = 8'h38,
    opc_jmp_abs = 8'h4c, opc_nop = 8'hea
  } opcode_t;

  typedef enum logic [2:0] {
    mode_imm, mode_abs, mode_abs_x, mode_abs_y, mode_zpg, mode_impl
  } addr_mode_t;

  typedef enum logic [3:0] {
    st_fetch, st_decode, st_mem1, st_mem2, st_mem3, st_mem4,
    st_exec1, st_exec2, st_exec3, st_invalid
  } instr_state_t;

  typedef enum logic [3:0] {
    op_load, op_store, op_adc, op_sbc, op_logic, op_cmp, op_transfer,
    op_inc, op_clc, op_sec, op_jmp, op_nop, op_invalid
  } op_class_t;

  typedef enum logic [1:0] {reg_a, reg_x, reg_y} reg_t;

  typedef enum logic [1:0] {alu_add, alu_and, alu_or, alu_xor} alu_op_t;

  typedef enum logic [2:0] {
    data_src_data_in, data_src_a, data_src_x, data_src_y, data_src_alu
  } data_bus_src_t;

  typedef enum logic {addr_low_src_pc, addr_low_src_reg} addr_low_src_t;

  typedef enum logic [1:0] {
    addr_high_src_pc, addr_high_src_reg, addr_high_src_zero
  } addr_high_src_t;

  // Bit positions in the control word.
  typedef enum logic [4:0] {
    ctrl_load_inst_reg, ctrl_inc_pc, ctrl_load_pc,
    ctrl_load_addr_low, ctrl_load_addr_high, ctrl_inc_addr_high,
    ctrl_load_input_a, ctrl_load_input_b, ctrl_reset_input_a, ctrl_alu_carry_in,
    ctrl_alu_invert_b,
    ctrl_load_a, ctrl_load_x, ctrl_load_y,
    ctrl_update_n, ctrl_update_z, ctrl_update_c, ctrl_update_v, ctrl_set_carry,
    ctrl_clear_carry,
    ctrl_write,
    ctrl_count
  } ctrl_bit_t;

  typedef logic [ctrl_count-1:0] ctrl_word_t;

endpackage

// ==== source/execute_phase.sv ====
`timescale 1ns/1ps

module execute_phase (
  input  cpu_pkg::instr_state_t  state,
  input  cpu_pkg::op_class_t     op_class,
  input  cpu_pkg::reg_t          reg_sel,
  input  cpu_pkg::reg_t          src_sel,
  input  cpu_pkg::alu_op_t       alu_sel,
  input  cpu_pkg::addr_mode_t    mode,
  input  logic                   carry_flag,
  output cpu_pkg::ctrl_word_t    ctrl,
  output cpu_pkg::data_bus_src_t data_bus_src,
  output cpu_pkg::alu_op_t       alu_op,
  output cpu_pkg::instr_state_t  next_state
);
  import cpu_pkg::*;

  logic write_back;
  logic set_nz;

  function automatic data_bus_src_t reg_src(reg_t r);
    case (r)
      reg_x: return data_src_x;
      reg_y: return data_src_y;
      default: return data_src_a;
    endcase
  endfunction

  function automatic ctrl_bit_t reg_load(reg_t r);
    case (r)
      reg_x: return ctrl_load_x;
      reg_y: return ctrl_load_y;
      default: return ctrl_load_a;
    endcase
  endfunction

  always_comb begin
    ctrl = '0;
    data_bus_src = data_src_data_in;
    alu_op = alu_sel;
    next_state = st_fetch;
    write_back = 1'b0;
    set_nz = 1'b0;
    case (op_class)
      op_load: write_back = 1'b1;
      op_store: begin
        data_bus_src = reg_src(reg_sel);
        ctrl[ctrl_write] = 1'b1;
      end
      op_transfer: begin
        data_bus_src = reg_src(src_sel);
        write_back = 1'b1;
      end
      op_inc: begin
        if (state == st_exec1) begin
          data_bus_src = reg_src(reg_sel);
          ctrl[ctrl_reset_input_a] = 1'b1;
          ctrl[ctrl_load_input_b] = 1'b1;
          next_state = st_exec2;
        end else begin
          data_bus_src = data_src_alu;
          ctrl[ctrl_alu_carry_in] = 1'b1; // Zero plus register plus one.
          write_back = 1'b1;
        end
      end
      op_adc, op_sbc, op_logic, op_cmp: begin
        case (state)
          st_exec1: begin
            ctrl[ctrl_load_input_b] = 1'b1; // Memory operand.
            next_state = st_exec2;
          end
          st_exec2: begin
            data_bus_src = reg_src(reg_sel);
            ctrl[ctrl_load_input_a] = 1'b1;
            next_state = st_exec3;
          end
          default: begin
            data_bus_src = data_src_alu;
            ctrl[ctrl_alu_invert_b] = op_class inside {op_sbc, op_cmp};
            ctrl[ctrl_alu_carry_in] = carry_flag && (op_class inside {op_adc, op_sbc});
            ctrl[ctrl_update_c] = op_class != op_logic;
            ctrl[ctrl_update_v] = op_class inside {op_adc, op_sbc};
            write_back = op_class != op_cmp; // Compare only sets flags.
            set_nz = 1'b1;
          end
        endcase
      end
      op_clc: ctrl[ctrl_clear_carry] = 1'b1;
      op_sec: ctrl[ctrl_set_carry] = 1'b1;
      op_jmp: ctrl[ctrl_load_pc] = 1'b1;
      default: next_state = st_invalid;
    endcase
    if (write_back) begin
      ctrl[reg_load(reg_sel)] = 1'b1;
    end
    if (write_back || set_nz) begin
      ctrl[ctrl_update_n] = 1'b1;
      ctrl[ctrl_update_z] = 1'b1;
    end
    // Step past the immediate operand.
    if (state == st_exec1 && mode == mode_imm) begin
      ctrl[ctrl_inc_pc] = 1'b1;
    end
  end

endmodule

// ==== source/opcode_decoder.sv ====
`timescale 1ns/1ps

module opcode_decoder (
  input  cpu_pkg::opcode_t   opcode,
  output cpu_pkg::addr_mode_t mode,
  output cpu_pkg::op_class_t op_class,
  output cpu_pkg::reg_t      reg_sel,
  output cpu_pkg::reg_t      src_sel,
  output cpu_pkg::alu_op_t   alu_sel,
  output logic               valid
);
  import cpu_pkg::*;

  function automatic void set_fields(addr_mode_t m, op_class_t c, reg_t r, alu_op_t a,
                                     reg_t s = reg_a);
    mode = m;
    op_class = c;
    reg_sel = r;
    alu_sel = a;
    src_sel = s; // Source register, transfers only.
  endfunction

  always_comb begin
    valid = 1'b1;
    case (opcode)
      opc_lda_imm:  set_fields(mode_imm, op_load, reg_a, alu_add);
      opc_lda_abs:  set_fields(mode_abs, op_load, reg_a, alu_add);
      opc_lda_absx: set_fields(mode_abs_x, op_load, reg_a, alu_add);
      opc_lda_absy: set_fields(mode_abs_y, op_load, reg_a, alu_add);
      opc_lda_zpg:  set_fields(mode_zpg, op_load, reg_a, alu_add);
      opc_ldx_imm:  set_fields(mode_imm, op_load, reg_x, alu_add);
      opc_ldx_abs:  set_fields(mode_abs, op_load, reg_x, alu_add);
      opc_ldx_absy: set_fields(mode_abs_y, op_load, reg_x, alu_add);
      opc_ldx_zpg:  set_fields(mode_zpg, op_load, reg_x, alu_add);
      opc_ldy_imm:  set_fields(mode_imm, op_load, reg_y, alu_add);
      opc_ldy_abs:  set_fields(mode_abs, op_load, reg_y, alu_add);
      opc_ldy_absx: set_fields(mode_abs_x, op_load, reg_y, alu_add);
      opc_ldy_zpg:  set_fields(mode_zpg, op_load, reg_y, alu_add);
      opc_sta_abs:  set_fields(mode_abs, op_store, reg_a, alu_add);
      opc_sta_absx: set_fields(mode_abs_x, op_store, reg_a, alu_add);
      opc_sta_absy: set_fields(mode_abs_y, op_store, reg_a, alu_add);
      opc_sta_zpg:  set_fields(mode_zpg, op_store, reg_a, alu_add);
      opc_stx_abs:  set_fields(mode_abs, op_store, reg_x, alu_add);
      opc_stx_zpg:  set_fields(mode_zpg, op_store, reg_x, alu_add);
      opc_sty_abs:  set_fields(mode_abs, op_store, reg_y, alu_add);
      opc_sty_zpg:  set_fields(mode_zpg, op_store, reg_y, alu_add);
      opc_adc_imm:  set_fields(mode_imm, op_adc, reg_a, alu_add);
      opc_adc_abs:  set_fields(mode_abs, op_adc, reg_a, alu_add);
      opc_adc_absx: set_fields(mode_abs_x, op_adc, reg_a, alu_add);
      opc_adc_absy: set_fields(mode_abs_y, op_adc, reg_a, alu_add);
      opc_adc_zpg:  set_fields(mode_zpg, op_adc, reg_a, alu_add);
      opc_sbc_imm:  set_fields(mode_imm, op_sbc, reg_a, alu_add);
      opc_sbc_abs:  set_fields(mode_abs, op_sbc, reg_a, alu_add);
      opc_sbc_absx: set_fields(mode_abs_x, op_sbc, reg_a, alu_add);
      opc_sbc_absy: set_fields(mode_abs_y, op_sbc, reg_a, alu_add);
      opc_sbc_zpg:  set_fields(mode_zpg, op_sbc, reg_a, alu_add);
      opc_cmp_imm:  set_fields(mode_imm, op_cmp, reg_a, alu_add);
      opc_cmp_abs:  set_fields(mode_abs, op_cmp, reg_a, alu_add);
      opc_cmp_absx: set_fields(mode_abs_x, op_cmp, reg_a, alu_add);
      opc_cmp_absy: set_fields(mode_abs_y, op_cmp, reg_a, alu_add);
      opc_cmp_zpg:  set_fields(mode_zpg, op_cmp, reg_a, alu_add);
      opc_cpx_imm:  set_fields(mode_imm, op_cmp, reg_x, alu_add);
      opc_cpx_abs:  set_fields(mode_abs, op_cmp, reg_x, alu_add);
      opc_cpx_zpg:  set_fields(mode_zpg, op_cmp, reg_x, alu_add);
      opc_cpy_imm:  set_fields(mode_imm, op_cmp, reg_y, alu_add);
      opc_cpy_abs:  set_fields(mode_abs, op_cmp, reg_y, alu_add);
      opc_cpy_zpg:  set_fields(mode_zpg, op_cmp, reg_y, alu_add);
      opc_and_imm:  set_fields(mode_imm, op_logic, reg_a, alu_and);
      opc_and_abs:  set_fields(mode_abs, op_logic, reg_a, alu_and);
      opc_and_absx: set_fields(mode_abs_x, op_logic, reg_a, alu_and);
      opc_and_absy: set_fields(mode_abs_y, op_logic, reg_a, alu_and);
      opc_and_zpg:  set_fields(mode_zpg, op_logic, reg_a, alu_and);
      opc_ora_imm:  set_fields(mode_imm, op_logic, reg_a, alu_or);
      opc_ora_abs:  set_fields(mode_abs, op_logic, reg_a, alu_or);
      opc_ora_absx: set_fields(mode_abs_x, op_logic, reg_a, alu_or);
      opc_ora_absy: set_fields(mode_abs_y, op_logic, reg_a, alu_or);
      opc_ora_zpg:  set_fields(mode_zpg, op_logic, reg_a, alu_or);
      opc_eor_imm:  set_fields(mode_imm, op_logic, reg_a, alu_xor);
      opc_eor_abs:  set_fields(mode_abs, op_logic, reg_a, alu_xor);
      opc_eor_absx: set_fields(mode_abs_x, op_logic, reg_a, alu_xor);
      opc_eor_absy: set_fields(mode_abs_y, op_logic, reg_a, alu_xor);
      opc_eor_zpg:  set_fields(mode_zpg, op_logic, reg_a, alu_xor);
      opc_tax:      set_fields(mode_impl, op_transfer, reg_x, alu_add, reg_a);
      opc_tay:      set_fields(mode_impl, op_transfer, reg_y, alu_add, reg_a);
      opc_txa:      set_fields(mode_impl, op_transfer, reg_a, alu_add, reg_x);
      opc_tya:      set_fields(mode_impl, op_transfer, reg_a, alu_add, reg_y);
      opc_inx:      set_fields(mode_impl, op_inc, reg_x, alu_add);
      opc_iny:      set_fields(mode_impl, op_inc, reg_y, alu_add);
      opc_clc:      set_fields(mode_impl, op_clc, reg_a, alu_add);
      opc_sec:      set_fields(mode_impl, op_sec, reg_a, alu_add);
      opc_jmp_abs:  set_fields(mode_abs, op_jmp, reg_a, alu_add);
      opc_nop:      set_fields(mode_impl, op_nop, reg_a, alu_add);
      default: begin
        valid = 1'b0;
        set_fields(mode_impl, op_invalid, reg_a, alu_add);
      end
    endcase
  end

endmodule

// ==== test/control_unit_props.sv ====
`timescale 1ns/1ps

module control_unit_props (
  input logic                clk,
  input logic                reset,
  input cpu_pkg::ctrl_word_t ctrl,
  input logic                halted
);
  import cpu_pkg::*;

  int unsigned failures = 0; // Summed into the testbench error count.

  no_write_in_fetch: assert property (
    @(posedge clk) disable iff (reset) !(ctrl[ctrl_write] && ctrl[ctrl_load_inst_reg])
  ) else begin
    failures++;
    $error("write strobe raised during an instruction fetch");
  end

  // Only reset leaves the trapped state.
  halt_holds: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
  else begin
    failures++;
    $error("halted dropped without reset");
  end

  quiet_when_halted: assert property (@(posedge clk) disable iff (reset) halted |-> ctrl == '0)
  else begin
    failures++;
    $error("strobes active while halted");
  end

endmodule

bind control_unit control_unit_props props0 (
  .clk(clk), .reset(reset), .ctrl(ctrl), .halted(halted)
);

// ==== test/control_unit_tb.sv ====
`timescale 1ns/1ps

module control_unit_tb;
  import cpu_pkg::*;

  localparam int num_instr = 300;
  localparam int watchdog_cycles = num_instr * 9 + 200;
  localparam int num_tests = 6;
  localparam int t_reset = 0;
  localparam int t_length = 1;
  localparam int t_store = 2;
  localparam int t_regs = 3;
  localparam int t_alu = 4;
  localparam int t_invalid = 5;

  logic clk;
  logic reset;
  opcode_t opcode;
  logic carry_flag;
  ctrl_word_t ctrl;
  alu_op_t alu_op;
  data_bus_src_t data_bus_src;
  addr_low_src_t addr_low_src;
  addr_high_src_t addr_high_src;
  logic halted;

  logic [31:0] lfsr;
  string test_names [num_tests] = '{"reset_state", "instr_length", "stores",
                                    "reg_loads_flags", "alu_controls", "invalid_opcode"};
  int checks [num_tests] = '{default: 0};
  int errors [num_tests] = '{default: 0};

  // Model view of the instruction in flight.
  addr_mode_t exp_mode;
  op_class_t exp_class;
  reg_t exp_reg;
  alu_op_t exp_alu;

  logic [7:0] kept [67] = '{
    8'ha9, 8'had, 8'hbd, 8'hb9, 8'ha5, 8'ha2, 8'hae, 8'hbe, 8'ha6, 8'ha0,
    8'hac, 8'hbc, 8'ha4, 8'h8d, 8'h9d, 8'h99, 8'h85, 8'h8e, 8'h86, 8'h8c,
    8'h84, 8'h69, 8'h6d, 8'h7d, 8'h79, 8'h65, 8'he9, 8'hed, 8'hfd, 8'hf9,
    8'he5, 8'hc9, 8'hcd, 8'hdd, 8'hd9, 8'hc5, 8'he0, 8'hec, 8'he4, 8'hc0,
    8'hcc, 8'hc4, 8'h29, 8'h2d, 8'h3d, 8'h39, 8'h25, 8'h09, 8'h0d, 8'h1d,
    8'h19, 8'h05, 8'h49, 8'h4d, 8'h5d, 8'h59, 8'h45, 8'haa, 8'ha8, 8'h8a,
    8'h98, 8'he8, 8'hc8, 8'h18, 8'h38, 8'h4c, 8'hea
  };

  tb_clock #(.period_ns(40)) clock0 (.clk(clk));

  control_unit dut0 (
    .clk(clk), .reset(reset), .opcode(opcode), .carry_flag(carry_flag), .ctrl(ctrl),
    .alu_op(alu_op), .data_bus_src(data_bus_src), .addr_low_src(addr_low_src),
    .addr_high_src(addr_high_src), .halted(halted)
  );

  // Galois LFSR, one step per bit taken.
  function automatic logic [31:0] random_bits(int n);
    logic [31:0] value;
    int k;
    value = '0;
    for (k = 0; k < n; k++) begin
      value = {value[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return value;
  endfunction

  function automatic logic is_kept(logic [7:0] op);
    foreach (kept[k]) begin
      if (kept[k] == op) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic logic [7:0] pick_kept();
    return kept[random_bits(7) % 67];
  endfunction

  function automatic logic [7:0] pick_invalid();
    logic [7:0] op;
    op = 8'(random_bits(8));
    while (is_kept(op)) begin
      op = 8'(random_bits(8));
    end
    return op;
  endfunction

  function automatic void compare_value(int id, string what, int expected, int actual);
    checks[id]++;
    if (expected != actual) begin
      errors[id]++;
      $display("FAIL %s %s: expected %0h, actual %0h", test_names[id], what, expected, actual);
    end
  endfunction

  function automatic void finish_test(int id);
    $display("test %s finished: %0d checks, %0d errors", test_names[id], checks[id], errors[id]);
  endfunction

  function automatic void set_class(op_class_t c, reg_t r, alu_op_t a);
    exp_class = c;
    exp_reg = r;
    exp_alu = a;
  endfunction

  // Fields from the 6502 opcode layout aaa_bbb_cc.
  function automatic void derive_fields(logic [7:0] op);
    exp_mode = mode_impl;
    case (op)
      8'haa: set_class(op_transfer, reg_x, alu_add);
      8'ha8: set_class(op_transfer, reg_y, alu_add);
      8'h8a: set_class(op_transfer, reg_a, alu_add);
      8'h98: set_class(op_transfer, reg_a, alu_add);
      8'he8: set_class(op_inc, reg_x, alu_add);
      8'hc8: set_class(op_inc, reg_y, alu_add);
      8'h18: set_class(op_clc, reg_a, alu_add);
      8'h38: set_class(op_sec, reg_a, alu_add);
      8'hea: set_class(op_nop, reg_a, alu_add);
      8'h4c: begin
        exp_mode = mode_abs;
        set_class(op_jmp, reg_a, alu_add);
      end
      default: begin
        case (op[4:2])
          3'b000, 3'b010: exp_mode = mode_imm;
          3'b001: exp_mode = mode_zpg;
          3'b011: exp_mode = mode_abs;
          3'b110: exp_mode = mode_abs_y;
          default: begin
            if (op[1:0] == 2'b10) begin
              exp_mode = mode_abs_y; // LDX indexes by Y.
            end else begin
              exp_mode = mode_abs_x;
            end
          end
        endcase
        case ({op[1:0], op[7:5]})
          5'b01_000: set_class(op_logic, reg_a, alu_or);
          5'b01_001: set_class(op_logic, reg_a, alu_and);
          5'b01_010: set_class(op_logic, reg_a, alu_xor);
          5'b01_011: set_class(op_adc, reg_a, alu_add);
          5'b01_100: set_class(op_store, reg_a, alu_add);
          5'b01_101: set_class(op_load, reg_a, alu_add);
          5'b01_110: set_class(op_cmp, reg_a, alu_add);
          5'b01_111: set_class(op_sbc, reg_a, alu_add);
          5'b10_100: set_class(op_store, reg_x, alu_add);
          5'b10_101: set_class(op_load, reg_x, alu_add);
          5'b00_100: set_class(op_store, reg_y, alu_add);
          5'b00_101: set_class(op_load, reg_y, alu_add);
          5'b00_110: set_class(op_cmp, reg_y, alu_add);
          5'b00_111: set_class(op_cmp, reg_x, alu_add);
          default: set_class(op_invalid, reg_a, alu_add);
        endcase
      end
    endcase
  endfunction

  // Fetch and decode, then mode cycles, then execute cycles.
  function automatic int expected_length(logic carry);
    int n;
    n = 2;
    case (exp_mode)
      mode_abs: n = n + 1;
      mode_abs_x, mode_abs_y: n = n + 3 + int'(carry);
      default: ;
    endcase
    case (exp_class)
      op_inc: n = n + 2;
      op_adc, op_sbc, op_logic, op_cmp: n = n + 3;
      op_nop: ;
      default: n = n + 1;
    endcase
    return n;
  endfunction

  function automatic data_bus_src_t reg_source(reg_t r);
    if (r == reg_x) begin
      return data_src_x;
    end else if (r == reg_y) begin
      return data_src_y;
    end
    return data_src_a;
  endfunction

  function automatic logic [2:0] load_mask(reg_t r);
    if (r == reg_x) begin
      return 3'b010;
    end else if (r == reg_y) begin
      return 3'b100;
    end
    return 3'b001;
  endfunction

  task automatic apply_reset();
    reset = 1'b1;
    repeat (3) @(negedge clk);
    reset = 1'b0; // Ends in the first fetch cycle.
  endtask

  task automatic check_fetch_word(int id, string when);
    ctrl_word_t word;
    word = '0;
    word[ctrl_load_inst_reg] = 1'b1;
    word[ctrl_inc_pc] = 1'b1;
    compare_value(id, {"control word ", when}, word, ctrl);
    compare_value(id, {"halted ", when}, 0, halted);
  endtask

  // Starts and ends on the falling edge of a fetch cycle.
  task automatic run_instruction(logic [7:0] op, logic carry);
    int cycles;
    int writes;
    int load_cycles;
    int halted_cycles;
    data_bus_src_t write_data;
    addr_low_src_t write_low;
    addr_high_src_t write_high;
    addr_high_src_t exp_high;
    ctrl_word_t last_ctrl;
    alu_op_t last_alu;
    logic writes_reg;
    logic arith;
    logic is_cmp;
    string tag;
    cycles = 1;
    writes = 0;
    load_cycles = 0;
    halted_cycles = 0;
    write_data = data_src_data_in;
    write_low = addr_low_src_pc;
    write_high = addr_high_src_pc;
    last_ctrl = '0;
    last_alu = alu_add;
    tag = $sformatf(" of %02h", op);
    opcode = opcode_t'(op);
    carry_flag = carry;
    derive_fields(op);
    @(negedge clk);
    while (!ctrl[ctrl_load_inst_reg]) begin
      cycles++;
      if (ctrl[ctrl_write]) begin
        writes++;
        write_data = data_bus_src;
        write_low = addr_low_src;
        write_high = addr_high_src;
      end
      if (ctrl[ctrl_load_a] || ctrl[ctrl_load_x] || ctrl[ctrl_load_y]) begin
        load_cycles++;
      end
      if (halted) begin
        halted_cycles++;
      end
      last_ctrl = ctrl;
      last_alu = alu_op;
      @(negedge clk);
    end
    writes_reg = exp_class inside {op_load, op_transfer, op_inc, op_adc, op_sbc, op_logic};
    arith = exp_class inside {op_adc, op_sbc};
    is_cmp = exp_class == op_cmp;
    compare_value(t_length, {"cycles", tag}, expected_length(carry), cycles);
    compare_value(t_length, {"halted cycles", tag}, 0, halted_cycles);
    compare_value(t_store, {"writes", tag}, int'(exp_class == op_store), writes);
    if (exp_class == op_store) begin
      exp_high = (exp_mode == mode_zpg) ? addr_high_src_zero : addr_high_src_reg;
      compare_value(t_store, {"data source", tag}, reg_source(exp_reg), write_data);
      compare_value(t_store, {"low address source", tag}, addr_low_src_reg, write_low);
      compare_value(t_store, {"high address source", tag}, exp_high, write_high);
    end
    compare_value(t_regs, {"load cycles", tag}, int'(writes_reg), load_cycles);
    compare_value(t_regs, {"load strobes", tag}, writes_reg ? load_mask(exp_reg) : 3'b000,
                  {last_ctrl[ctrl_load_y], last_ctrl[ctrl_load_x], last_ctrl[ctrl_load_a]});
    compare_value(t_regs, {"flags nzcv", tag},
                  {writes_reg || is_cmp, writes_reg || is_cmp, arith || is_cmp, arith},
                  {last_ctrl[ctrl_update_n], last_ctrl[ctrl_update_z],
                   last_ctrl[ctrl_update_c], last_ctrl[ctrl_update_v]});
    compare_value(t_alu, {"alu_op", tag}, exp_alu, last_alu);
    compare_value(t_alu, {"invert_b", tag}, int'(exp_class inside {op_sbc, op_cmp}),
                  last_ctrl[ctrl_alu_invert_b]);
    if (arith || is_cmp) begin
      compare_value(t_alu, {"carry_in", tag}, int'(arith && carry),
                    last_ctrl[ctrl_alu_carry_in]);
    end
    compare_value(t_alu, {"clc sec jmp strobes", tag},
                  {exp_class == op_clc, exp_class == op_sec, exp_class == op_jmp},
                  {last_ctrl[ctrl_clear_carry], last_ctrl[ctrl_set_carry],
                   last_ctrl[ctrl_load_pc]});
  endtask

  task automatic run_invalid(logic [7:0] op);
    int k;
    string tag;
    tag = $sformatf(" of %02h", op);
    opcode = opcode_t'(op);
    @(negedge clk);
    compare_value(t_invalid, {"halted in decode", tag}, 0, halted);
    @(negedge clk);
    compare_value(t_invalid, {"halted", tag}, 1, halted);
    for (k = 0; k < 6; k++) begin
      @(negedge clk);
      compare_value(t_invalid, {"halted while trapped", tag}, 1, halted);
      compare_value(t_invalid, {"fetch while trapped", tag}, 0, ctrl[ctrl_load_inst_reg]);
    end
    apply_reset();
    check_fetch_word(t_invalid, "after reset");
  endtask

  initial begin
    int i;
    int total_checks;
    int total_errors;
    logic [7:0] op;
    logic carry;
    logic [4:0] roll;
    reset = 1'b1;
    opcode = opc_nop;
    carry_flag = 1'b0;
    lfsr = 32'hc7eb_47a8;
    apply_reset();
    check_fetch_word(t_reset, "first cycle");
    finish_test(t_reset);
    for (i = 0; i < num_instr; i++) begin
      roll = 5'(random_bits(5));
      if (i == num_instr / 2 || roll == 5'd0) begin
        op = pick_invalid();
        run_invalid(op);
      end else begin
        op = pick_kept();
        carry = 1'(random_bits(1));
        run_instruction(op, carry);
      end
    end
    for (i = t_length; i <= t_invalid; i++) begin
      finish_test(i);
    end
    total_checks = 0;
    total_errors = dut0.props0.failures;
    for (i = 0; i < num_tests; i++) begin
      total_checks += checks[i];
      total_errors += errors[i];
    end
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             num_tests, total_checks, total_errors, dut0.props0.failures);
    if (total_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Worst case is nine cycles per instruction.
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: run still going after %0d cycles", watchdog_cycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

endmodule
